// File: bus_cfg_pkg.sv
// bus configuration package: system sizes for the multi-master serial bus

package bus_cfg_pkg;

  ////////////////////
  // system sizes
  ////////////////////
  localparam int NO_MASTERS = 3;
  localparam int NO_SLAVES  = 3;

  // slave id 0 means no slave
  localparam int S_ID_WIDTH = $clog2(NO_SLAVES + 1);
  localparam int M_ID_WIDTH = $clog2(NO_MASTERS);  // owner index

  localparam int WR_WIDTH     = 3;                       // reply code length
  localparam int ID_CNT_WIDTH = $clog2(S_ID_WIDTH + 1);  // id bit counter

endpackage : bus_cfg_pkg

// File: bus_controller.sv
// bus controller: fixed priority arbiter with split and pause, routes owner data
`timescale 1ns/10ps

module bus_controller import bus_cfg_pkg::*; import bus_proto_pkg::*; (
  input  logic                  clk,
  input  logic                  rstN,
  input  port_status_t          status [NO_MASTERS],
  input  logic [NO_SLAVES:1]    slave_ready,
  input  logic [NO_MASTERS-1:0] port_in_bus,
  output cmd_t                  cmd [NO_MASTERS],
  output logic [NO_SLAVES:1]    slave_data
);

  logic [NO_MASTERS-1:0] eligible;
  logic                  lower_split;
  logic                  any_req;
  logic [M_ID_WIDTH-1:0] winner;
  logic [M_ID_WIDTH-1:0] owner;
  logic [S_ID_WIDTH-1:0] own_id;
  logic                  busy;
  logic                  paused;
  logic [NO_MASTERS-1:0] split_mask;
  com_state_t            owner_state;
  logic                  owner_ready;
  logic                  granting;
  logic                  routing;

  ////////////////////
  // arbitration
  ////////////////////
  // masters above a pending split master wait for it
  always_comb begin
    lower_split = 1'b0;
    for (int i = 0; i < NO_MASTERS; i++) begin
      eligible[i] = (status[i].id != '0) && !lower_split;
      lower_split = lower_split | split_mask[i];
    end
  end

  always_comb begin
    winner  = '0;
    any_req = 1'b0;
    for (int i = NO_MASTERS - 1; i >= 0; i--) begin
      if (eligible[i]) begin
        winner  = M_ID_WIDTH'(i);  // lowest index wins
        any_req = 1'b1;
      end
    end
  end

  assign owner_state = status[owner].com_state;
  assign owner_ready = slave_ready[own_id];
  assign granting    = (cmd[owner] == CLEAR);  // port status not updated yet
  assign routing     = busy && !paused && (owner_state == COM);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < NO_MASTERS; i++) cmd[i] <= CMD_IDLE;
      owner      <= '0;
      own_id     <= '0;
      busy       <= 1'b0;
      paused     <= 1'b0;
      split_mask <= '0;
    end else begin
      for (int i = 0; i < NO_MASTERS; i++) cmd[i] <= CMD_IDLE;  // one cycle cmds
      if (!busy) begin
        if (any_req) begin
          cmd[winner]        <= CLEAR;
          owner              <= winner;
          own_id             <= status[winner].id;
          busy               <= 1'b1;
          split_mask[winner] <= 1'b0;
        end
      end else if (paused) begin
        // resume once the slave is back and the master asked for it
        if (owner_ready && status[owner].done) begin
          cmd[owner] <= CLEAR;
          paused     <= 1'b0;
        end
      end else if (!granting) begin
        if (owner_state == END_COM || owner_state == NAK) begin
          busy <= 1'b0;
        end else if (owner_state == COM && any_req && winner < owner) begin
          cmd[owner]        <= STOP_S;
          split_mask[owner] <= 1'b1;
          busy              <= 1'b0;  // lower master takes over
        end else if (owner_state == COM && !owner_ready) begin
          cmd[owner] <= STOP_P;
          paused     <= 1'b1;
        end
      end
    end
  end

  ////////////////////
  // data routing
  ////////////////////
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      slave_data <= '0;
    end else begin
      slave_data <= '0;
      if (routing) slave_data[own_id] <= port_in_bus[owner];  // one cycle late
    end
  end

endmodule : bus_controller

// File: bus_proto_pkg.sv
// bus protocol package: commands, comm states, frame codes and port status

package bus_proto_pkg;
  import bus_cfg_pkg::*;

  ////////////////////
  // controller to port
  ////////////////////
  typedef enum logic [1:0] {
    CMD_IDLE = 2'b00,
    STOP_S   = 2'b01,  // split stop
    STOP_P   = 2'b10,  // plain stop, slave not ready
    CLEAR    = 2'b11
  } cmd_t;

  typedef enum logic [1:0] {
    END_COM  = 2'b00,
    NAK      = 2'b01,
    WAIT_ACK = 2'b10,
    COM      = 2'b11
  } com_state_t;

  ////////////////////
  // reply codes, sent lsb first
  ////////////////////
  localparam logic [WR_WIDTH-1:0] REP_ZERO   = 3'b000;
  localparam logic [WR_WIDTH-1:0] REP_NEW    = 3'b011;  // master sees 110
  localparam logic [WR_WIDTH-1:0] REP_RESUME = 3'b001;  // master sees 100
  localparam logic [WR_WIDTH-1:0] REP_GO     = 3'b111;
  localparam logic [WR_WIDTH-1:0] REP_PAUSE  = 3'b010;

  // frames from the master, oldest bit on the left
  localparam int PAT_WIDTH = 3;
  localparam logic [PAT_WIDTH-1:0] PRE_REQ    = 3'b111;
  localparam logic [PAT_WIDTH-1:0] ACK_PAT    = 3'b101;
  localparam logic [PAT_WIDTH-1:0] NAK_PAT    = 3'b110;
  localparam logic [1:0]           END_PAT    = 2'b01;
  localparam logic [PAT_WIDTH-1:0] RESUME_PAT = 3'b010;

  typedef enum logic [2:0] {
    PS_RST,
    PS_START,
    PS_ALLOC1,
    PS_ALLOC2,
    PS_ACK,
    PS_COM,
    PS_DONE,
    PS_OVER
  } port_state_t;

  // what a port tells the controller
  typedef struct packed {
    logic [S_ID_WIDTH-1:0] id;
    com_state_t            com_state;
    logic                  done;
  } port_status_t;

endpackage : bus_proto_pkg

// File: list.f
bus_cfg_pkg.sv
bus_proto_pkg.sv
write_buffer.sv
master_port.sv
bus_controller.sv
serial_bus_top.sv
tb_serial_bus.sv

// File: master_port.sv
// master port: decodes request frames of one master and sends reply codes
`timescale 1ns/10ps

module master_port import bus_cfg_pkg::*; import bus_proto_pkg::*; (
  input  logic         clk,
  input  logic         rstN,
  input  logic         port_in,
  output logic         port_out,
  input  cmd_t         cmd,
  output port_status_t status
);

  port_state_t             state;
  port_state_t             next_state;
  logic [PAT_WIDTH-1:0]    in_buf;    // newest bit at lsb
  logic [ID_CNT_WIDTH-1:0] bit_cnt;
  logic [S_ID_WIDTH-1:0]   slave_id;
  com_state_t              com_state;
  logic                    done;
  logic                    split;     // stopped by STOP_S earlier
  logic                    id_full;
  logic                    flush;
  logic [WR_WIDTH-1:0]     wr_code;
  logic                    wr_load;

  write_buffer i_write_buffer (
    .clk  (clk),
    .rstN (rstN),
    .din  (wr_code),
    .load (wr_load),
    .dout (port_out)
  );

  assign id_full = (bit_cnt == ID_CNT_WIDTH'(S_ID_WIDTH));

  // drop stale bits when a new pattern is awaited
  assign flush = (next_state != state) &&
                 ((next_state == PS_ACK) || (next_state == PS_DONE));

  ////////////////////
  // next state and replies
  ////////////////////
  always_comb begin
    next_state = state;
    wr_code    = REP_ZERO;
    wr_load    = 1'b0;
    unique case (state)
      PS_RST: next_state = PS_START;
      PS_START: begin
        if (in_buf == PRE_REQ) next_state = PS_ALLOC1;
      end
      PS_ALLOC1: begin
        if (id_full) begin
          // id 0 is no request
          next_state = (in_buf[S_ID_WIDTH-1:0] != '0) ? PS_ALLOC2 : PS_START;
        end
      end
      PS_ALLOC2: begin
        if (cmd == CLEAR) begin
          wr_code    = split ? REP_RESUME : REP_NEW;
          wr_load    = 1'b1;
          next_state = PS_ACK;
        end
      end
      PS_ACK: begin
        if (in_buf == NAK_PAT) begin
          next_state = PS_OVER;  // no go code on nak
        end else if (in_buf == ACK_PAT) begin
          wr_code    = REP_GO;
          wr_load    = 1'b1;
          next_state = PS_COM;
        end
      end
      PS_COM: begin
        if (cmd == STOP_S) begin
          wr_load    = 1'b1;
          next_state = PS_DONE;
        end else if (cmd == STOP_P) begin
          wr_code    = REP_PAUSE;
          wr_load    = 1'b1;
          next_state = PS_DONE;
        end else if (in_buf[1:0] == END_PAT) begin
          wr_load    = 1'b1;
          next_state = PS_OVER;
        end
      end
      PS_DONE: begin
        if (in_buf == RESUME_PAT) next_state = PS_ALLOC2;
      end
      PS_OVER: next_state = PS_START;
      default: next_state = PS_RST;
    endcase
  end

  ////////////////////
  // state and handshake flags
  ////////////////////
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state     <= PS_RST;
      in_buf    <= '0;
      bit_cnt   <= '0;
      com_state <= END_COM;
      done      <= 1'b0;
      split     <= 1'b0;
    end else begin
      state  <= next_state;
      in_buf <= flush ? '0 : {in_buf[PAT_WIDTH-2:0], port_in};
      case (state)
        PS_START: bit_cnt <= ID_CNT_WIDTH'(1);  // first id bit arrives now
        PS_ALLOC1: bit_cnt <= bit_cnt + 1'b1;
        PS_ALLOC2: begin
          if (cmd == CLEAR) begin
            com_state <= WAIT_ACK;
            done      <= 1'b0;
            split     <= 1'b0;
          end
        end
        PS_ACK: begin
          if (in_buf == NAK_PAT) com_state <= NAK;
          else if (in_buf == ACK_PAT) com_state <= COM;
        end
        PS_COM: begin
          if (cmd == STOP_S) begin
            com_state <= WAIT_ACK;
            split     <= 1'b1;
          end else if (cmd == STOP_P) begin
            com_state <= WAIT_ACK;
          end else if (in_buf[1:0] == END_PAT) begin
            com_state <= END_COM;
          end
        end
        PS_DONE: if (in_buf == RESUME_PAT) done <= 1'b1;
        default: ;
      endcase
    end
  end

  // slave id of the last request
  always_ff @(posedge clk) begin
    if (state == PS_ALLOC1 && id_full) slave_id <= in_buf[S_ID_WIDTH-1:0];
  end

  // id is shown only while waiting for a grant
  assign status.id        = (state == PS_ALLOC2) ? slave_id : '0;
  assign status.com_state = com_state;
  assign status.done      = done;

endmodule : master_port

// File: serial_bus_top.sv
// serial bus top: master ports and the bus controller
`timescale 1ns/10ps

module serial_bus_top import bus_cfg_pkg::*; import bus_proto_pkg::*; (
  input  logic                  clk,
  input  logic                  rstN,
  input  logic [NO_MASTERS-1:0] master_in,
  output logic [NO_MASTERS-1:0] master_out,
  input  logic [NO_SLAVES:1]    slave_ready,
  output logic [NO_SLAVES:1]    slave_data
);

  port_status_t status [NO_MASTERS];
  cmd_t         cmd    [NO_MASTERS];

  ////////////////////
  // one port per master
  ////////////////////
  for (genvar m = 0; m < NO_MASTERS; m++) begin : g_port
    master_port i_master_port (
      .clk      (clk),
      .rstN     (rstN),
      .port_in  (master_in[m]),
      .port_out (master_out[m]),
      .cmd      (cmd[m]),
      .status   (status[m])
    );
  end

  // arbiter sees the raw master lines for data routing
  bus_controller i_bus_controller (
    .clk         (clk),
    .rstN        (rstN),
    .status      (status),
    .slave_ready (slave_ready),
    .port_in_bus (master_in),
    .cmd         (cmd),
    .slave_data  (slave_data)
  );

endmodule : serial_bus_top

// File: tb_serial_bus.sv
// directed testbench for the serial bus top with master and slave models
`timescale 1ns/10ps

module tb_serial_bus import bus_cfg_pkg::*; import bus_proto_pkg::*; ();

  localparam int CLK_PERIOD  = 20;
  localparam int REPLY_LIMIT = 40;   // cycles to wait for a reply code
  localparam int TEST_CYCLES = 250;  // budget of one test
  localparam int WATCHDOG    = 6 * TEST_CYCLES + 500;

  // reply codes in the order the master sees them
  localparam logic [2:0] SEEN_NEW    = 3'b110;
  localparam logic [2:0] SEEN_RESUME = 3'b100;
  localparam logic [2:0] SEEN_GO     = 3'b111;
  localparam logic [2:0] SEEN_PAUSE  = 3'b010;

  logic                  clk;
  logic                  rstN;
  logic [NO_MASTERS-1:0] master_in;
  logic [NO_MASTERS-1:0] master_out;
  logic [NO_SLAVES:1]    slave_ready;
  logic [NO_SLAVES:1]    slave_data;
  integer                seed;
  int                    checks;
  int                    errors;

  serial_bus_top i_dut (
    .clk         (clk),
    .rstN        (rstN),
    .master_in   (master_in),
    .master_out  (master_out),
    .slave_ready (slave_ready),
    .slave_data  (slave_data)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    repeat (WATCHDOG) @(posedge clk);
    $display("watchdog expired after %0d cycles, the tests did not finish", WATCHDOG);
    $display("STATUS: FAIL");
    $finish;
  end

  ////////////////////
  // checks and master model
  ////////////////////
  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  // sends msb first with one bit per falling edge
  task automatic drive_bits(input int m, input logic [7:0] bits, input int n);
    for (int i = n - 1; i >= 0; i--) begin
      @(negedge clk);
      master_in[m] = bits[i];
    end
  endtask

  task automatic request_bus(input int m, input logic [S_ID_WIDTH-1:0] id);
    drive_bits(m, {PRE_REQ, id}, PAT_WIDTH + S_ID_WIDTH);
    @(negedge clk);
    master_in[m] = 1'b0;
  endtask

  // window starts at the first one as leading zeros look like the idle line
  task automatic wait_reply(input int m, input logic [2:0] expected, input string name);
    logic [2:0] window;
    logic       seen;
    int         lead;
    int         n;
    window = '0;
    seen   = 1'b0;
    n      = 0;
    lead   = expected[2] ? 0 : (expected[1] ? 1 : 2);
    while (!seen && n < REPLY_LIMIT) begin
      @(negedge clk);
      window = {window[1:0], master_out[m]};
      seen   = (master_out[m] === 1'b1);
      n++;
    end
    if (!seen) begin
      errors++;
      $display("%s: master %0d got no reply code within %0d cycles", name, m, REPLY_LIMIT);
    end else begin
      repeat (2 - lead) begin
        @(negedge clk);
        window = {window[1:0], master_out[m]};
      end
      check_value(name, expected, window);
    end
  endtask

  task automatic stays_silent(input int m, input int n, input string name);
    repeat (n) begin
      @(negedge clk);
      check_value(name, 1'b0, master_out[m]);
    end
  endtask

  // ack and go code followed by data routed to slave s one cycle late
  task automatic go_transfer(input int m, input int s, input int n, input string name);
    logic               last;
    logic [NO_SLAVES:1] routed;
    int                 rnd;
    drive_bits(m, ACK_PAT, PAT_WIDTH);  // line stays high after the ack
    wait_reply(m, SEEN_GO, name);
    last = 1'b1;
    for (int i = 0; i <= n; i++) begin
      @(negedge clk);
      routed    = '0;
      routed[s] = last;
      check_value(name, routed, slave_data);
      rnd = $random(seed);
      // data stays 0 after its first 0 so it never holds the end pattern
      last = (i < n) ? (last & (rnd[1:0] != 2'b00)) : 1'b0;
      master_in[m] = last;
    end
  endtask

  task automatic end_transfer(input int m, input string name);
    drive_bits(m, END_PAT, 2);
    @(negedge clk);
    master_in[m] = 1'b0;
    repeat (2) @(negedge clk);
    check_value(name, '0, slave_data);  // all slave lines idle again
  endtask

  task automatic send_resume(input int m);
    drive_bits(m, RESUME_PAT, PAT_WIDTH);
    @(negedge clk);
    master_in[m] = 1'b0;
  endtask

  ////////////////////
  // directed tests
  ////////////////////
  task automatic reset_values();
    repeat (4) begin
      @(negedge clk);
      check_value("reset master_out", '0, master_out);
      check_value("reset slave_data", '0, slave_data);
    end
  endtask

  task automatic grant_and_transfer();
    request_bus(1, 2);
    wait_reply(1, SEEN_NEW, "grant new code");
    go_transfer(1, 2, 10, "grant transfer");
    end_transfer(1, "grant end");
  endtask

  task automatic nak_frees_bus();
    request_bus(1, 1);
    wait_reply(1, SEEN_NEW, "nak new code");
    request_bus(2, 3);  // queued behind master 1
    drive_bits(1, NAK_PAT, PAT_WIDTH);
    fork
      stays_silent(1, 8, "nak no go code");
      wait_reply(2, SEEN_NEW, "nak next grant");
    join
    go_transfer(2, 3, 6, "nak next transfer");
    end_transfer(2, "nak next end");
  endtask

  task automatic fixed_priority();
    fork
      request_bus(0, 1);
      request_bus(2, 2);
    join
    fork
      begin
        wait_reply(0, SEEN_NEW, "priority first grant");
        go_transfer(0, 1, 8, "priority first transfer");
        end_transfer(0, "priority first end");
      end
      stays_silent(2, 16, "priority second waits");
    join
    wait_reply(2, SEEN_NEW, "priority second grant");
    go_transfer(2, 2, 6, "priority second transfer");
    end_transfer(2, "priority second end");
  endtask

  task automatic split_and_resume();
    request_bus(2, 1);
    wait_reply(2, SEEN_NEW, "split new code");
    go_transfer(2, 1, 6, "split first transfer");
    fork
      begin
        request_bus(0, 3);
        wait_reply(0, SEEN_NEW, "split lower grant");
      end
      stays_silent(2, 14, "split zero code");  // stop code is all zeros
    join
    @(negedge clk);
    master_in[2] = 1'b1;  // stopped line must not reach its slave
    repeat (2) @(negedge clk);
    check_value("split data stops", '0, slave_data);
    go_transfer(0, 3, 6, "split lower transfer");
    end_transfer(0, "split lower end");
    send_resume(2);
    wait_reply(2, SEEN_RESUME, "split resume code");
    go_transfer(2, 1, 4, "split resumed transfer");
    end_transfer(2, "split resumed end");
  endtask

  task automatic pause_and_resume();
    request_bus(0, 1);
    wait_reply(0, SEEN_NEW, "pause new code");
    go_transfer(0, 1, 6, "pause transfer");
    @(negedge clk);
    slave_ready[1] = 1'b0;  // slave back-pressure
    wait_reply(0, SEEN_PAUSE, "pause code");
    for (int i = 0; i < 4; i++) begin
      @(negedge clk);
      master_in[0] = 1'b1;  // busy line must not reach the slave
      check_value("pause data stops", '0, slave_data);
    end
    @(negedge clk);
    master_in[0]   = 1'b0;
    slave_ready[1] = 1'b1;
    send_resume(0);
    wait_reply(0, SEEN_NEW, "pause resume code");
    go_transfer(0, 1, 4, "pause resumed transfer");
    end_transfer(0, "pause end");
  endtask

  ////////////////////
  // main sequence
  ////////////////////
  initial begin
    rstN        = 1'b0;
    master_in   = '0;
    slave_ready = '1;
    seed        = 32'h9e20c24d;
    checks      = 0;
    errors      = 0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;
    reset_values();
    grant_and_transfer();
    nak_frees_bus();
    fixed_priority();
    split_and_resume();
    pause_and_resume();
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule : tb_serial_bus

// File: write_buffer.sv
// write buffer: loads a reply code and shifts it to the master lsb first
`timescale 1ns/10ps

module write_buffer import bus_cfg_pkg::*; (
  input  logic                clk,
  input  logic                rstN,
  input  logic [WR_WIDTH-1:0] din,
  input  logic                load,
  output logic                dout
);

  logic [WR_WIDTH-1:0] shift_q;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      shift_q <= '0;
    end else if (load) begin
      shift_q <= din;
    end else begin
      shift_q <= {1'b0, shift_q[WR_WIDTH-1:1]};  // zero fill
    end
  end

  // empty buffer holds only zeros
  assign dout = shift_q[0];

endmodule : write_buffer
